// ==== logic/fir_pkg.sv ====
`default_nettype none

package fir_pkg;

	localparam int TAP_COUNT = 25;
	localparam int SAMPLE_WIDTH = 16;
	localparam int ACC_WIDTH = 37;
	localparam int SHIFT_WIDTH = 5;
	localparam int TREE_DEPTH = 5;
	localparam int COEF_IDX_WIDTH = $clog2(TAP_COUNT);

	localparam int AXIL_ADDR_WIDTH = 12;
	localparam int AXIL_DATA_WIDTH = 32;
	localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;
	localparam logic [AXIL_ADDR_WIDTH-1:0] COEF_END_ADDR = 12'h064;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL_ADDR = 12'h064;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_COUNT_ADDR = 12'h068;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// bit positions inside the control register.
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_FLUSH_BIT = 1;
	localparam int CTRL_SHIFT_LSB = 8;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic signed [SAMPLE_WIDTH-1:0] coef_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// element 0 is the newest sample.
	typedef sample_t [TAP_COUNT-1:0] tap_vec_t;
	typedef coef_t [TAP_COUNT-1:0] coef_vec_t;

	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = -16'sh8000;

	typedef struct packed {
		logic enable;
		logic [SHIFT_WIDTH-1:0] shift;
	} fir_cfg_t;

	typedef struct packed {
		logic awvalid;
		logic [AXIL_ADDR_WIDTH-1:0] awaddr;
		logic wvalid;
		logic [AXIL_DATA_WIDTH-1:0] wdata;
		logic [AXIL_STRB_WIDTH-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [AXIL_ADDR_WIDTH-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [AXIL_DATA_WIDTH-1:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

// ==== logic/tap_delay_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module tap_delay_line import fir_pkg::*; (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire sample_t in_sample,
	input wire enable,
	input wire flush,
	output tap_vec_t taps,
	output logic tap_valid
);

	logic accept;

	// a flush drops the sample offered in the same cycle.
	assign accept = in_valid && enable && !flush;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			taps <= '0;
			tap_valid <= 1'b0;
		end
		else
		begin
			tap_valid <= accept;
			if (flush)
			begin
				taps <= '0;
			end
			else if (accept)
			begin
				taps <= {taps[TAP_COUNT-2:0], in_sample};
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		in_valid |-> !$isunknown(in_sample));

endmodule

`default_nettype wire

// ==== logic/fir_coef_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_coef_regs import fir_pkg::*; (
	input wire clk,
	input wire reset,
	input wire axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input wire out_valid,
	output fir_cfg_t cfg,
	output coef_vec_t coefs,
	output logic flush
);

	logic wr_ready;
	logic wr_fire;
	logic bvalid;
	logic [1:0] bresp;
	logic rd_ready;
	logic rd_fire;
	logic rvalid;
	logic [AXIL_DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic [AXIL_DATA_WIDTH-1:0] out_count;
	logic [AXIL_DATA_WIDTH-1:0] ctrl_word;
	logic [AXIL_DATA_WIDTH-1:0] ctrl_merged;
	logic [AXIL_DATA_WIDTH-1:0] coef_merged;
	logic [COEF_IDX_WIDTH-1:0] wr_idx;
	logic [COEF_IDX_WIDTH-1:0] rd_idx;
	logic [AXIL_DATA_WIDTH-1:0] rd_data_next;
	logic [1:0] rd_resp_next;

	function automatic logic [AXIL_DATA_WIDTH-1:0] merge_bytes(
		input logic [AXIL_DATA_WIDTH-1:0] old_word,
		input logic [AXIL_DATA_WIDTH-1:0] new_word,
		input logic [AXIL_STRB_WIDTH-1:0] strb
	);
		logic [AXIL_DATA_WIDTH-1:0] merged;
		merged = old_word;
		for (int b = 0; b < AXIL_STRB_WIDTH; b++)
		begin
			if (strb[b])
				merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

	// the low two address bits are ignored because all registers are word wide.
	assign wr_idx = axil_req.awaddr[COEF_IDX_WIDTH+1:2];
	assign rd_idx = axil_req.araddr[COEF_IDX_WIDTH+1:2];

	assign wr_fire = wr_ready && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = rd_ready && axil_req.arvalid;

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[CTRL_ENABLE_BIT] = cfg.enable;
		ctrl_word[CTRL_SHIFT_LSB +: SHIFT_WIDTH] = cfg.shift;
	end

	assign ctrl_merged = merge_bytes(ctrl_word, axil_req.wdata, axil_req.wstrb);
	assign coef_merged = merge_bytes({16'b0, coefs[wr_idx]}, axil_req.wdata,
		axil_req.wstrb);

	always_comb
	begin
		rd_data_next = '0;
		rd_resp_next = RESP_OKAY;
		if (axil_req.araddr < COEF_END_ADDR)
			rd_data_next = {16'b0, coefs[rd_idx]};
		else if (axil_req.araddr[AXIL_ADDR_WIDTH-1:2] == REG_CTRL_ADDR[AXIL_ADDR_WIDTH-1:2])
			rd_data_next = ctrl_word;
		else if (axil_req.araddr[AXIL_ADDR_WIDTH-1:2] == REG_COUNT_ADDR[AXIL_ADDR_WIDTH-1:2])
			rd_data_next = out_count;
		else
			rd_resp_next = RESP_SLVERR;
	end

	// write channel. awready and wready rise together for a single cycle.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			coefs <= '0;
			cfg <= '0;
			flush <= 1'b0;
		end
		else
		begin
			wr_ready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_ready;
			flush <= 1'b0;
			if (wr_fire)
			begin
				bvalid <= 1'b1;
				bresp <= RESP_OKAY;
				if (axil_req.awaddr < COEF_END_ADDR)
				begin
					coefs[wr_idx] <= coef_merged[SAMPLE_WIDTH-1:0];
				end
				else if (axil_req.awaddr[AXIL_ADDR_WIDTH-1:2] ==
					REG_CTRL_ADDR[AXIL_ADDR_WIDTH-1:2])
				begin
					cfg.enable <= ctrl_merged[CTRL_ENABLE_BIT];
					cfg.shift <= ctrl_merged[CTRL_SHIFT_LSB +: SHIFT_WIDTH];
					flush <= ctrl_merged[CTRL_FLUSH_BIT];
				end
				else if (axil_req.awaddr[AXIL_ADDR_WIDTH-1:2] !=
					REG_COUNT_ADDR[AXIL_ADDR_WIDTH-1:2])
				begin
					bresp <= RESP_SLVERR;
				end
			end
			else if (axil_req.bready)
			begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_ready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
		end
		else
		begin
			rd_ready <= axil_req.arvalid && !rvalid && !rd_ready;
			if (rd_fire)
			begin
				rvalid <= 1'b1;
				rdata <= rd_data_next;
				rresp <= rd_resp_next;
			end
			else if (axil_req.rready)
			begin
				rvalid <= 1'b0;
			end
		end
	end

	// the count wraps at 32 bits.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			out_count <= '0;
		else if (out_valid)
			out_count <= out_count + 1'b1;
	end

	always_comb
	begin
		axil_rsp.awready = wr_ready;
		axil_rsp.wready = wr_ready;
		axil_rsp.bvalid = bvalid;
		axil_rsp.bresp = bresp;
		axil_rsp.arready = rd_ready;
		axil_rsp.rvalid = rvalid;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
	end

	assert property (@(posedge clk) disable iff (reset)
		bvalid && !axil_req.bready |=> bvalid && $stable(bresp));

	assert property (@(posedge clk) disable iff (reset)
		rvalid && !axil_req.rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== logic/fir_mac_tree.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_mac_tree import fir_pkg::*; (
	input wire clk,
	input wire reset,
	input wire tap_vec_t taps,
	input wire tap_valid,
	input wire coef_vec_t coefs,
	input wire [4:0] shift,
	output logic out_valid,
	output sample_t out_sample
);

	// node count of tree level lvl as it shrinks from 25 through 13 7 4 2 to 1.
	function automatic int level_size(input int lvl);
		return (TAP_COUNT + (1 << lvl) - 1) >> lvl;
	endfunction

	// level 0 holds the products and level TREE_DEPTH node 0 the full sum.
	acc_t tree [0:TREE_DEPTH][0:TAP_COUNT-1];
	logic [TREE_DEPTH:0] stage_valid;
	acc_t shifted;
	sample_t saturated;

	always_ff @(posedge clk)
	begin
		for (int k = 0; k < TAP_COUNT; k++)
		begin
			tree[0][k] <= $signed(taps[k]) * $signed(coefs[k]);
		end
	end

	for (genvar lvl = 1; lvl <= TREE_DEPTH; lvl++)
	begin : g_level
		localparam int IN_SIZE = level_size(lvl - 1);
		localparam int OUT_SIZE = level_size(lvl);

		for (genvar i = 0; i < OUT_SIZE; i++)
		begin : g_node
			if (2 * i + 1 < IN_SIZE)
			begin : g_add
				always_ff @(posedge clk)
				begin
					tree[lvl][i] <= tree[lvl-1][2*i] + tree[lvl-1][2*i+1];
				end
			end
			else
			begin : g_pass
				// the odd node left over moves up a level unchanged.
				always_ff @(posedge clk)
				begin
					tree[lvl][i] <= tree[lvl-1][2*i];
				end
			end
		end
	end

	always_comb
	begin
		shifted = tree[TREE_DEPTH][0] >>> shift;
		if (shifted > SAMPLE_MAX)
			saturated = SAMPLE_MAX;
		else if (shifted < SAMPLE_MIN)
			saturated = SAMPLE_MIN;
		else
			saturated = shifted[SAMPLE_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		out_sample <= saturated;
	end

	// stage_valid[0] marks the products and stage_valid[TREE_DEPTH] the full sum.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stage_valid <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			stage_valid <= {stage_valid[TREE_DEPTH-1:0], tap_valid};
			out_valid <= stage_valid[TREE_DEPTH];
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		tap_valid |-> ##(TREE_DEPTH + 2) out_valid);

	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(tap_valid, TREE_DEPTH + 2));

endmodule

`default_nettype wire

// ==== logic/fir_filter_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_filter_top import fir_pkg::*; (
	input wire clk,
	input wire reset,
	input wire axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input wire in_valid,
	input wire sample_t in_sample,
	output logic out_valid,
	output sample_t out_sample
);

	fir_cfg_t cfg;
	coef_vec_t coefs;
	logic flush;
	tap_vec_t taps;
	logic tap_valid;

	fir_coef_regs fir_coef_regs_inst (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.out_valid(out_valid),
		.cfg(cfg),
		.coefs(coefs),
		.flush(flush)
	);

	tap_delay_line tap_delay_line_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_sample(in_sample),
		.enable(cfg.enable),
		.flush(flush),
		.taps(taps),
		.tap_valid(tap_valid)
	);

	// coefficients are taken at the multiply stage of the tree.
	fir_mac_tree fir_mac_tree_inst (
		.clk(clk),
		.reset(reset),
		.taps(taps),
		.tap_valid(tap_valid),
		.coefs(coefs),
		.shift(cfg.shift),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

endmodule

`default_nettype wire

// ==== sim/fir_tb_tests.svh ====
`ifndef FIR_TB_TESTS_SVH
`define FIR_TB_TESTS_SVH

// direct form FIR over the accepted history, then shift and clamp to 16 bits.
function automatic sample_t fir_ref(input sample_t s);
	longint sum;
	longint shifted;
	for (int k = TAP_COUNT - 1; k > 0; k--)
		ref_hist[k] = ref_hist[k-1];
	ref_hist[0] = s;
	sum = 0;
	for (int k = 0; k < TAP_COUNT; k++)
		sum += longint'(ref_hist[k]) * longint'(ref_coef[k]);
	shifted = sum >>> ref_shift;
	if (shifted > 32767)
		return 16'sh7fff;
	if (shifted < -32768)
		return sample_t'(16'h8000);
	return sample_t'(shifted);
endfunction

task automatic clear_reference();
	for (int k = 0; k < TAP_COUNT; k++)
	begin
		ref_hist[k] = '0;
		ref_coef[k] = '0;
	end
	ref_enable = 1'b0;
	ref_shift = '0;
endtask

task automatic start_test(input string name);
	current_test = name;
	errors_at_start = error_count;
endtask

task automatic finish_test();
	if (error_count == errors_at_start)
	begin
		$display("test %s passed", current_test);
		tests_passed++;
	end
	else
	begin
		$display("test %s failed with %0d errors", current_test, error_count - errors_at_start);
		tests_failed++;
	end
endtask

task automatic send_sample(input sample_t s);
	in_valid = 1'b1;
	in_sample = s;
	if (ref_enable)
	begin
		exp_q.push_back(fir_ref(s));
		accepted_count++;
	end
	@(posedge clk);
	#2;
	in_valid = 1'b0;
endtask

task automatic idle_cycles(input int n);
	repeat (n) @(posedge clk);
	#2;
endtask

task automatic wait_drain();
	while (exp_q.size() != 0)
		@(negedge clk);
	idle_cycles(1);
endtask

task automatic set_coef(input int k, input coef_t value);
	logic [1:0] resp;
	axil_write(AXIL_ADDR_WIDTH'(4 * k), {16'b0, value}, 4'hf, resp);
	check_resp("bresp", 2'b00, resp);
	ref_coef[k] = value;
endtask

task automatic set_ctrl(input logic enable, input logic [4:0] shift, input logic flush);
	logic [1:0] resp;
	axil_write(12'h064, {19'b0, shift, 6'b0, flush, enable}, 4'hf, resp);
	check_resp("bresp", 2'b00, resp);
	ref_enable = enable;
	ref_shift = shift;
	if (flush)
	begin
		for (int k = 0; k < TAP_COUNT; k++)
			ref_hist[k] = '0;
	end
endtask

task automatic after_reset_values();
	logic [31:0] data;
	logic [1:0] resp;
	start_test("after_reset");
	for (int k = 0; k < TAP_COUNT + 2; k++)
	begin
		axil_read(AXIL_ADDR_WIDTH'(4 * k), data, resp);
		check_rdata("rdata", 32'h0, data);
		check_resp("rresp", 2'b00, resp);
	end
	// enable is still clear, so these samples must not produce output.
	for (int i = 0; i < 5; i++)
		send_sample(sample_t'($random(seed)));
	idle_cycles(12);
	finish_test();
endtask

task automatic register_access();
	logic [31:0] data;
	logic [1:0] resp;
	start_test("register_access");
	axil_write(12'h00c, 32'h0000_1234, 4'hf, resp);
	axil_write(12'h00c, 32'h0000_abcd, 4'b0010, resp);
	axil_write(12'h00c, 32'hffff_0000, 4'b1100, resp);
	axil_read(12'h00c, data, resp);
	check_rdata("coef3", 32'h0000_ab34, data);
	axil_write(12'h064, 32'h0000_0345, 4'b0010, resp);
	axil_read(12'h064, data, resp);
	check_rdata("ctrl", 32'h0000_0300, data);
	axil_read(12'h06c, data, resp);
	check_resp("rresp", 2'b10, resp);
	axil_write(12'h100, 32'h1, 4'hf, resp);
	check_resp("bresp", 2'b10, resp);
	axil_write(12'h068, 32'hdead_beef, 4'hf, resp);
	check_resp("bresp", 2'b00, resp);
	axil_read(12'h068, data, resp);
	check_rdata("count", 32'h0, data);
	axil_write(12'h00c, 32'h0, 4'hf, resp);
	axil_write(12'h064, 32'h0, 4'hf, resp);
	finish_test();
endtask

task automatic impulse_response();
	start_test("impulse");
	for (int k = 0; k < TAP_COUNT; k++)
		set_coef(k, coef_t'(k * 1031 - 9000));
	set_ctrl(1'b1, 5'd0, 1'b1);
	// each output of a unit impulse is the next coefficient.
	for (int k = 0; k < TAP_COUNT; k++)
	begin
		in_valid = 1'b1;
		in_sample = (k == 0) ? 16'sd1 : 16'sd0;
		void'(fir_ref(in_sample));
		exp_q.push_back(ref_coef[k]);
		accepted_count++;
		@(posedge clk);
		#2;
	end
	in_valid = 1'b0;
	wait_drain();
	finish_test();
endtask

task automatic random_stream();
	logic [31:0] data;
	logic [1:0] resp;
	int gap;
	start_test("random_stream");
	for (int k = 0; k < TAP_COUNT; k++)
		set_coef(k, coef_t'($random(seed)));
	set_ctrl(1'b1, 5'd15, 1'b1);
	for (int i = 0; i < 300; i++)
	begin
		send_sample(sample_t'($random(seed)));
		gap = $random(seed) & 3;
		if (gap >= 2)
			idle_cycles(gap - 1);
	end
	wait_drain();
	axil_read(12'h068, data, resp);
	check_rdata("count", accepted_count, data);
	finish_test();
endtask

task automatic flush_and_enable();
	start_test("flush_enable");
	for (int i = 0; i < 10; i++)
		send_sample(sample_t'($random(seed)));
	wait_drain();
	set_ctrl(1'b1, 5'd15, 1'b1);
	for (int i = 0; i < 5; i++)
		send_sample(sample_t'($random(seed)));
	wait_drain();
	set_ctrl(1'b0, 5'd15, 1'b0);
	for (int i = 0; i < 5; i++)
		send_sample(sample_t'($random(seed)));
	idle_cycles(12);
	set_ctrl(1'b1, 5'd15, 1'b0);
	for (int i = 0; i < 10; i++)
		send_sample(sample_t'($random(seed)));
	wait_drain();
	finish_test();
endtask

task automatic saturation();
	start_test("saturation");
	for (int k = 0; k < TAP_COUNT; k++)
		set_coef(k, 16'sh7fff);
	set_ctrl(1'b1, 5'd0, 1'b1);
	repeat (TAP_COUNT) send_sample(16'sh7fff);
	wait_drain();
	check_sample("out_sample", 16'sh7fff, last_out);
	repeat (TAP_COUNT) send_sample(sample_t'(16'h8000));
	wait_drain();
	check_sample("out_sample", sample_t'(16'h8000), last_out);
	finish_test();
endtask

task automatic run_tests();
	after_reset_values();
	register_access();
	impulse_response();
	random_stream();
	flush_and_enable();
	saturation();
endtask

`endif

// ==== sim/fir_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_tb import fir_pkg::*; ();

	logic clk;
	logic reset;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic in_valid;
	sample_t in_sample;
	logic out_valid;
	sample_t out_sample;

	// reference model state and the results it still expects.
	sample_t exp_q[$];
	sample_t ref_hist [TAP_COUNT];
	coef_t ref_coef [TAP_COUNT];
	logic ref_enable;
	logic [SHIFT_WIDTH-1:0] ref_shift;

	sample_t last_out;
	string current_test;
	int seed;
	int error_count;
	int errors_at_start;
	int tests_passed;
	int tests_failed;
	int unsigned accepted_count;
	int unsigned cycle_count;
	int unsigned cycle_limit;

	fir_filter_top fir_filter_top_inst (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.in_valid(in_valid),
		.in_sample(in_sample),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_sample(input string name, input sample_t expected,
		input sample_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_rdata(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
		input logic [31:0] data, input logic [3:0] strb, output logic [1:0] resp);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		@(negedge clk);
		while (!(axil_rsp.awready && axil_rsp.wready))
			@(negedge clk);
		@(posedge clk);
		#2;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		axil_req.bready = 1'b1;
		@(negedge clk);
		while (!axil_rsp.bvalid)
			@(negedge clk);
		resp = axil_rsp.bresp;
		@(posedge clk);
		#2;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr,
		output logic [31:0] data, output logic [1:0] resp);
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		@(negedge clk);
		while (!axil_rsp.arready)
			@(negedge clk);
		@(posedge clk);
		#2;
		axil_req.arvalid = 1'b0;
		axil_req.rready = 1'b1;
		@(negedge clk);
		while (!axil_rsp.rvalid)
			@(negedge clk);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		#2;
		axil_req.rready = 1'b0;
	endtask

	`include "fir_tb_tests.svh"

	// outputs are compared at the falling edge, half a cycle after they settle.
	always @(negedge clk)
	begin
		if (!reset && out_valid)
		begin
			last_out = out_sample;
			if (exp_q.size() == 0)
			begin
				$display("at %0t out_valid was high while no result was expected", $time);
				error_count++;
			end
			else
				check_sample("out_sample", exp_q.pop_front(), out_sample);
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout in test %s after %0d cycles", current_test, cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial
	begin
		seed = 32'h7852;
		cycle_count = 0;
		cycle_limit = 20000;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		accepted_count = 0;
		current_test = "reset";
		axil_req = '0;
		in_valid = 1'b0;
		in_sample = '0;
		clear_reference();
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		@(posedge clk);
		#2;
		run_tests();
		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+sim
logic/fir_pkg.sv
logic/tap_delay_line.sv
logic/fir_coef_regs.sv
logic/fir_mac_tree.sv
logic/fir_filter_top.sv
sim/fir_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Mdir obj_dir --top-module fir_tb -f project.f

run: build
	./obj_dir/Vfir_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module fir_tb -f project.f
	verilator --lint-only -Wall --top-module fir_filter_top \
		logic/fir_pkg.sv logic/tap_delay_line.sv logic/fir_coef_regs.sv \
		logic/fir_mac_tree.sv logic/fir_filter_top.sv

clean:
	rm -rf obj_dir $(LOG)
